/* Bender.yml */
package:
  name: rv32_mem

export_include_dirs:
  - .

sources:
  - rv32_pkg.sv
  - rv32_branch_unit.sv
  - rv32_lsu_align.sv
  - rv32_csrs.sv
  - rv32_data_ram.sv
  - rv32_mem.sv
  - rv32_mem_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_rv32_mem.sv

/* rv32_branch_unit.sv */
module rv32_branch_unit (
    input  rv32_pkg::branch_op_t op,
    input  logic                 predicted_taken,
    input  logic [31:0]          result,
    output logic                 mispredicted
);
    import rv32_pkg::*;

    logic result_zero;
    logic taken;

    assign result_zero = (result == 32'd0);

    always_comb begin
        case (op)
            BRANCH_ZERO: begin
                taken = result_zero;
            end
            BRANCH_NON_ZERO: begin
                taken = !result_zero;
            end
            BRANCH_ALWAYS: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign mispredicted = taken != predicted_taken; // Fetch guessed wrong
endmodule

/* rv32_csrs.sv */
`include "rv32_defines.svh"

module rv32_csrs (
    input  logic              clk,
    input  logic              reset,
    input  logic              write_en,
    input  rv32_pkg::csr_op_t op,
    input  logic              src,
    input  logic [31:0]       rs1_value,
    input  logic [31:0]       imm_value,
    input  logic [11:0]       csr,
    input  logic              instr_retired,
    output logic [31:0]       read_value,
    output logic [63:0]       cycle_out
);
    import rv32_pkg::*;

    logic [63:0] cycle;
    logic [63:0] instret;
    logic [31:0] mscratch;
    logic [31:0] src_value;
    logic [31:0] mscratch_next;
    logic        scratch_write;

    assign src_value = src ? imm_value : rs1_value; // Immediate form uses zimm
    assign scratch_write = write_en && (csr == `RV32_CSR_MSCRATCH);

    // Read-modify-write on mscratch
    always_comb begin
        case (op)
            CSR_RW: begin
                mscratch_next = src_value;
            end
            CSR_RS: begin
                mscratch_next = mscratch | src_value;
            end
            CSR_RC: begin
                mscratch_next = mscratch & ~src_value;
            end
            default: begin
                mscratch_next = mscratch;
            end
        endcase
    end

    // Counters are read-only from software
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle <= 64'd0;
            instret <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
            if (instr_retired) begin
                instret <= instret + 64'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= 32'd0;
        end else if (scratch_write) begin
            mscratch <= mscratch_next;
        end
    end

    always_comb begin
        case (csr)
            `RV32_CSR_CYCLE:    read_value = cycle[31:0];
            `RV32_CSR_CYCLEH:   read_value = cycle[63:32];
            `RV32_CSR_INSTRET:  read_value = instret[31:0];
            `RV32_CSR_INSTRETH: read_value = instret[63:32];
            `RV32_CSR_MSCRATCH: read_value = mscratch;
            default:            read_value = 32'd0;
        endcase
    end

    assign cycle_out = cycle;
endmodule

/* rv32_data_ram.sv */
`include "rv32_defines.svh"

module rv32_data_ram (
    input  logic        clk,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] address,
    input  logic [31:0] write_value,
    input  logic [3:0]  write_mask,
    output logic [31:0] read_value
);
    localparam int INDEX_BITS = $clog2(`RV32_RAM_WORDS);

    logic [31:0]           mem [0:`RV32_RAM_WORDS-1];
    logic [INDEX_BITS-1:0] index;

    // Word index, upper address bits are dropped
    assign index = address[INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (write_mask[i]) begin
                    mem[index][i*8 +: 8] <= write_value[i*8 +: 8];
                end
            end
        end
    end

    assign read_value = read ? mem[index] : 32'd0; // Same-cycle read
endmodule

/* rv32_defines.svh */
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Data RAM depth in 32-bit words
`define RV32_RAM_WORDS 256

// Counter CSRs, user read-only space
`define RV32_CSR_CYCLE    12'hC00
`define RV32_CSR_CYCLEH   12'hC80
`define RV32_CSR_INSTRET  12'hC02
`define RV32_CSR_INSTRETH 12'hC82

// Machine scratch register
`define RV32_CSR_MSCRATCH 12'h340

`endif

/* rv32_lsu_align.sv */
module rv32_lsu_align (
    input  rv32_pkg::mem_width_t width,
    input  logic [1:0]           address_low,
    input  logic                 zero_extend,
    input  logic [31:0]          store_value,
    input  logic [31:0]          read_word,
    output logic [31:0]          write_value,
    output logic [3:0]           write_mask,
    output logic [31:0]          load_value
);
    import rv32_pkg::*;

    logic [15:0] half_lane;
    logic [7:0]  byte_lane;
    logic        sign_bit;

    // Store data is replicated so every candidate lane carries it
    always_comb begin
        case (width)
            WIDTH_WORD: begin
                write_value = store_value;
                write_mask = 4'b1111;
            end
            WIDTH_HALF: begin
                write_value = {2{store_value[15:0]}};
                write_mask = address_low[1] ? 4'b1100 : 4'b0011;
            end
            WIDTH_BYTE: begin
                write_value = {4{store_value[7:0]}};
                write_mask = 4'b0001 << address_low;
            end
            default: begin
                write_value = store_value;
                write_mask = 4'b0000; // Unused encoding writes nothing
            end
        endcase
    end

    // Lane pick for loads
    always_comb begin
        half_lane = address_low[1] ? read_word[31:16] : read_word[15:0];

        case (address_low)
            2'd0: byte_lane = read_word[7:0];
            2'd1: byte_lane = read_word[15:8];
            2'd2: byte_lane = read_word[23:16];
            default: byte_lane = read_word[31:24];
        endcase
    end

    // Shift down and extend
    always_comb begin
        case (width)
            WIDTH_HALF: begin
                sign_bit = half_lane[15] & ~zero_extend;
                load_value = {{16{sign_bit}}, half_lane};
            end
            WIDTH_BYTE: begin
                sign_bit = byte_lane[7] & ~zero_extend;
                load_value = {{24{sign_bit}}, byte_lane};
            end
            default: begin
                sign_bit = 1'b0;
                load_value = read_word;
            end
        endcase
    end
endmodule

/* rv32_mem.sv */
module rv32_mem (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 valid_in,
    input  logic                 read,
    input  logic                 write,
    input  rv32_pkg::mem_width_t width,
    input  logic                 zero_extend,
    input  logic                 csr_read,
    input  logic                 csr_write,
    input  rv32_pkg::csr_op_t    csr_op,
    input  logic                 csr_src,
    input  logic [11:0]          csr,
    input  rv32_pkg::branch_op_t branch_op,
    input  logic                 branch_predicted_taken,
    input  logic [31:0]          branch_pc_in,
    input  logic [4:0]           rd_in,
    input  logic                 rd_write_in,
    input  logic [31:0]          result,
    input  logic [31:0]          rs1_value,
    input  logic [31:0]          rs2_value,
    input  logic [31:0]          imm_value,
    input  logic [31:0]          data_read_value,
    output logic                 valid_out,
    output logic [4:0]           rd_out,
    output logic                 rd_write_out,
    output logic [31:0]          rd_value_out,
    output logic                 branch_mispredicted,
    output logic [31:0]          branch_pc_out,
    output logic [63:0]          cycle_out,
    output logic                 data_read,
    output logic                 data_write,
    output logic [31:0]          data_address,
    output logic [31:0]          data_write_value,
    output logic [3:0]           data_write_mask
);
    logic        commit;
    logic [3:0]  lane_mask;
    logic [31:0] load_value;
    logic [31:0] csr_read_value;
    logic [31:0] wb_value;
    logic        mispredicted;

    // Side effects only for a live, moving instruction
    assign commit = valid_in && !stall && !flush;

    rv32_lsu_align u_lsu_align (
        .width       (width),
        .address_low (result[1:0]),
        .zero_extend (zero_extend),
        .store_value (rs2_value),
        .read_word   (data_read_value),
        .write_value (data_write_value),
        .write_mask  (lane_mask),
        .load_value  (load_value)
    );

    assign data_read = read;
    assign data_write = write && commit;
    assign data_address = result; // ALU computed the effective address
    assign data_write_mask = data_write ? lane_mask : 4'b0000;

    rv32_branch_unit u_branch_unit (
        .op              (branch_op),
        .predicted_taken (branch_predicted_taken),
        .result          (result),
        .mispredicted    (mispredicted)
    );

    assign branch_mispredicted = mispredicted && valid_in && !flush;
    assign branch_pc_out = branch_pc_in;

    rv32_csrs u_csrs (
        .clk           (clk),
        .reset         (reset),
        .write_en      (csr_write && commit),
        .op            (csr_op),
        .src           (csr_src),
        .rs1_value     (rs1_value),
        .imm_value     (imm_value),
        .csr           (csr),
        .instr_retired (valid_out), // Retires as it leaves this stage
        .read_value    (csr_read_value),
        .cycle_out     (cycle_out)
    );

    always_comb begin
        if (read) begin
            wb_value = load_value;
        end else if (csr_read) begin
            wb_value = csr_read_value;
        end else begin
            wb_value = result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            rd_out <= 5'd0;
            rd_write_out <= 1'b0;
            rd_value_out <= 32'd0;
        end else if (!stall) begin
            valid_out <= valid_in && !flush;
            rd_out <= rd_in;
            rd_write_out <= rd_write_in && !flush;
            rd_value_out <= wb_value;
        end
    end
endmodule

/* rv32_mem_top.sv */
module rv32_mem_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 valid_in,
    input  logic                 read,
    input  logic                 write,
    input  rv32_pkg::mem_width_t width,
    input  logic                 zero_extend,
    input  logic                 csr_read,
    input  logic                 csr_write,
    input  rv32_pkg::csr_op_t    csr_op,
    input  logic                 csr_src,
    input  logic [11:0]          csr,
    input  rv32_pkg::branch_op_t branch_op,
    input  logic                 branch_predicted_taken,
    input  logic [31:0]          branch_pc_in,
    input  logic [4:0]           rd_in,
    input  logic                 rd_write_in,
    input  logic [31:0]          result,
    input  logic [31:0]          rs1_value,
    input  logic [31:0]          rs2_value,
    input  logic [31:0]          imm_value,
    output logic                 valid_out,
    output logic [4:0]           rd_out,
    output logic                 rd_write_out,
    output logic [31:0]          rd_value_out,
    output logic                 branch_mispredicted,
    output logic [31:0]          branch_pc_out,
    output logic [63:0]          cycle_out
);
    logic        data_read;
    logic        data_write;
    logic [31:0] data_address;
    logic [31:0] data_write_value;
    logic [3:0]  data_write_mask;
    logic [31:0] data_read_value;

    rv32_mem u_rv32_mem (
        .clk                    (clk),
        .reset                  (reset),
        .stall                  (stall),
        .flush                  (flush),
        .valid_in               (valid_in),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .csr_read               (csr_read),
        .csr_write              (csr_write),
        .csr_op                 (csr_op),
        .csr_src                (csr_src),
        .csr                    (csr),
        .branch_op              (branch_op),
        .branch_predicted_taken (branch_predicted_taken),
        .branch_pc_in           (branch_pc_in),
        .rd_in                  (rd_in),
        .rd_write_in            (rd_write_in),
        .result                 (result),
        .rs1_value              (rs1_value),
        .rs2_value              (rs2_value),
        .imm_value              (imm_value),
        .data_read_value        (data_read_value),
        .valid_out              (valid_out),
        .rd_out                 (rd_out),
        .rd_write_out           (rd_write_out),
        .rd_value_out           (rd_value_out),
        .branch_mispredicted    (branch_mispredicted),
        .branch_pc_out          (branch_pc_out),
        .cycle_out              (cycle_out),
        .data_read              (data_read),
        .data_write             (data_write),
        .data_address           (data_address),
        .data_write_value       (data_write_value),
        .data_write_mask        (data_write_mask)
    );

    // Data bus
    rv32_data_ram u_data_ram (
        .clk         (clk),
        .read        (data_read),
        .write       (data_write),
        .address     (data_address),
        .write_value (data_write_value),
        .write_mask  (data_write_mask),
        .read_value  (data_read_value)
    );
endmodule

/* rv32_pkg.sv */
package rv32_pkg;

    // Load/store access width
    typedef enum logic [1:0] {
        WIDTH_WORD = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_BYTE = 2'b10
    } mem_width_t;

    // Branch condition evaluated on the ALU result
    typedef enum logic [1:0] {
        BRANCH_NEVER    = 2'b00,
        BRANCH_ZERO     = 2'b01,
        BRANCH_NON_ZERO = 2'b10,
        BRANCH_ALWAYS   = 2'b11
    } branch_op_t;

    // CSR write operation, low bits of funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

endpackage

/* sim.f */
+incdir+.
rv32_pkg.sv
rv32_branch_unit.sv
rv32_lsu_align.sv
rv32_csrs.sv
rv32_data_ram.sv
rv32_mem.sv
rv32_mem_top.sv
tb_clock_gen.sv
tb_rv32_mem.sv

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

/* tb_rv32_mem.sv */
`include "rv32_defines.svh"

module tb_rv32_mem;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32_pkg::*;

    localparam int RAM_BYTES = `RV32_RAM_WORDS * 4;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic        valid_in;
    logic        read;
    logic        write;
    mem_width_t  width;
    logic        zero_extend;
    logic        csr_read;
    logic        csr_write;
    csr_op_t     csr_op;
    logic        csr_src;
    logic [11:0] csr;
    branch_op_t  branch_op;
    logic        branch_predicted_taken;
    logic [31:0] branch_pc_in;
    logic [4:0]  rd_in;
    logic        rd_write_in;
    logic [31:0] result;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] imm_value;
    logic        valid_out;
    logic [4:0]  rd_out;
    logic        rd_write_out;
    logic [31:0] rd_value_out;
    logic        branch_mispredicted;
    logic [31:0] branch_pc_out;
    logic [63:0] cycle_out;

    logic [7:0]  ram_model [0:RAM_BYTES-1];
    logic [31:0] scratch_model;
    logic [63:0] cycle_model;
    logic [63:0] retired_model;
    logic        valid_model; // Stage register valid bit as driven
    int          pass_count;
    int          fail_count;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv32_mem_top u_rv32_mem_top (.*);

    always @(posedge clk) begin
        if (reset) begin
            cycle_model <= 64'd0;
            retired_model <= 64'd0;
            valid_model <= 1'b0;
        end else begin
            cycle_model <= cycle_model + 64'd1;
            if (valid_model) begin
                retired_model <= retired_model + 64'd1;
            end
            if (!stall) begin
                valid_model <= valid_in && !flush;
            end
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    task automatic set_idle();
        stall <= 1'b0;
        flush <= 1'b0;
        valid_in <= 1'b0;
        read <= 1'b0;
        write <= 1'b0;
        width <= WIDTH_WORD;
        zero_extend <= 1'b0;
        csr_read <= 1'b0;
        csr_write <= 1'b0;
        csr_op <= CSR_RW;
        csr_src <= 1'b0;
        csr <= 12'd0;
        branch_op <= BRANCH_NEVER;
        branch_predicted_taken <= 1'b0;
        branch_pc_in <= 32'd0;
        rd_in <= 5'd0;
        rd_write_in <= 1'b0;
        result <= 32'd0;
        rs1_value <= 32'd0;
        rs2_value <= 32'd0;
        imm_value <= 32'd0;
    endtask

    task automatic drive_mem(input logic rd_en, input logic wr_en, input mem_width_t w,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic zext, input logic [4:0] rd);
        valid_in <= 1'b1;
        read <= rd_en;
        write <= wr_en;
        width <= w;
        result <= addr; // ALU result carries the address
        rs2_value <= data;
        zero_extend <= zext;
        rd_in <= rd;
        rd_write_in <= rd_en;
    endtask

    function automatic logic [31:0] rand_addr(input logic [1:0] offset);
        return ($urandom % `RV32_RAM_WORDS) * 4 + offset;
    endfunction

    // Little-endian byte memory
    function automatic void model_store(input mem_width_t w, input logic [31:0] addr,
                                        input logic [31:0] data);
        int a;
        a = addr % RAM_BYTES;
        if (w == WIDTH_WORD) begin
            for (int k = 0; k < 4; k++) begin
                ram_model[(a & ~3) + k] = data[8*k +: 8];
            end
        end else if (w == WIDTH_HALF) begin
            ram_model[a & ~1] = data[7:0];
            ram_model[(a & ~1) + 1] = data[15:8];
        end else begin
            ram_model[a] = data[7:0];
        end
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_width_t w,
                                               input logic zext);
        int a;
        logic [15:0] h;
        logic [7:0] b;
        a = addr % RAM_BYTES;
        h = {ram_model[(a & ~1) + 1], ram_model[a & ~1]};
        b = ram_model[a];
        if (w == WIDTH_HALF) begin
            return zext ? {16'd0, h} : {{16{h[15]}}, h};
        end else if (w == WIDTH_BYTE) begin
            return zext ? {24'd0, b} : {{24{b[7]}}, b};
        end
        a = a & ~3;
        return {ram_model[a + 3], ram_model[a + 2], ram_model[a + 1], ram_model[a]};
    endfunction

    task automatic store(input mem_width_t w, input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        drive_mem(1'b0, 1'b1, w, addr, data, 1'b0, 5'd0);
        @(posedge clk); // RAM writes here
        set_idle();
        model_store(w, addr, data);
    endtask

    task automatic load(input mem_width_t w, input logic [31:0] addr, input logic zext);
        logic [4:0]  rd;
        logic [31:0] expected;
        rd = 5'($urandom);
        expected = model_load(addr, w, zext);
        @(posedge clk);
        drive_mem(1'b1, 1'b0, w, addr, $urandom, zext, rd);
        @(posedge clk);
        set_idle();
        @(negedge clk);
        check("valid_out", 1, valid_out);
        check("rd_out", rd, rd_out);
        check("rd_write_out", 1, rd_write_out);
        check("rd_value_out", expected, rd_value_out);
    endtask

    task automatic test_word_access();
        for (int i = 0; i < `RV32_RAM_WORDS; i++) begin
            store(WIDTH_WORD, i * 4, $urandom); // Every byte of the model known
        end
        for (int i = 0; i < 64; i++) begin
            if ($urandom_range(0, 1) == 1) begin
                store(WIDTH_WORD, rand_addr(2'd0), $urandom);
            end
            load(WIDTH_WORD, rand_addr(2'd0), 1'b0);
        end
    endtask

    task automatic test_sub_word();
        mem_width_t  w;
        logic [1:0]  offset;
        logic [31:0] addr;
        for (int i = 0; i < 96; i++) begin
            w = (i % 2 == 0) ? WIDTH_BYTE : WIDTH_HALF;
            offset = (w == WIDTH_HALF) ? 2'(((i / 2) % 2) * 2) : 2'((i / 2) % 4);
            addr = rand_addr(offset);
            store(w, addr, $urandom);
            load(w, addr, 1'($urandom));
            load(WIDTH_WORD, {addr[31:2], 2'b00}, 1'b0); // Other lanes untouched
        end
    endtask

    task automatic test_branch();
        branch_op_t  op;
        logic [31:0] value;
        logic [31:0] pc;
        logic        pred;
        logic        valid;
        logic        fl;
        logic        taken;
        logic [31:0] last_result;
        last_result = 32'd0;
        for (int i = 0; i < 200; i++) begin
            op = branch_op_t'($urandom_range(0, 3));
            value = ($urandom_range(0, 3) == 0) ? 32'd0 : $urandom;
            pc = $urandom;
            pred = 1'($urandom);
            valid = ($urandom_range(0, 3) != 0);
            fl = ($urandom_range(0, 3) == 0);
            @(posedge clk);
            branch_op <= op;
            result <= value;
            branch_pc_in <= pc;
            branch_predicted_taken <= pred;
            valid_in <= valid;
            flush <= fl;
            @(negedge clk);
            taken = (op == BRANCH_ALWAYS) || (op == BRANCH_ZERO && value == 0) ||
                    (op == BRANCH_NON_ZERO && value != 0);
            check("branch_mispredicted", valid && !fl && (taken != pred), branch_mispredicted);
            check("branch_pc_out", pc, branch_pc_out);
            check("rd_value_out", last_result, rd_value_out); // Plain ALU result writeback
            last_result = value;
        end
        @(posedge clk);
        set_idle();
    endtask

    task automatic csr_access(input logic wr, input csr_op_t op, input logic src,
                              input logic [11:0] addr, input logic [31:0] rs1,
                              input logic [31:0] imm);
        logic [31:0] expected;
        logic [31:0] operand;
        @(posedge clk);
        valid_in <= 1'b1;
        csr_read <= 1'b1;
        csr_write <= wr;
        csr_op <= op;
        csr_src <= src;
        csr <= addr;
        rs1_value <= rs1;
        imm_value <= imm;
        rd_write_in <= 1'b1;
        @(negedge clk);
        case (addr)
            `RV32_CSR_CYCLE:    expected = cycle_model[31:0];
            `RV32_CSR_CYCLEH:   expected = cycle_model[63:32];
            `RV32_CSR_INSTRET:  expected = retired_model[31:0];
            `RV32_CSR_INSTRETH: expected = retired_model[63:32];
            `RV32_CSR_MSCRATCH: expected = scratch_model;
            default:            expected = 32'd0;
        endcase
        check("cycle_out", cycle_model, cycle_out);
        operand = src ? imm : rs1;
        if (wr && addr == `RV32_CSR_MSCRATCH) begin
            if (op == CSR_RW) begin
                scratch_model = operand;
            end else if (op == CSR_RS) begin
                scratch_model = scratch_model | operand;
            end else begin
                scratch_model = scratch_model & ~operand;
            end
        end
        @(posedge clk);
        set_idle();
        @(negedge clk);
        check("rd_value_out", expected, rd_value_out); // Old value as the read comes first
    endtask

    task automatic test_csrs();
        logic [11:0] addr;
        int          sel;
        for (int i = 0; i < 160; i++) begin
            sel = $urandom_range(0, 7);
            case (sel)
                0: addr = `RV32_CSR_CYCLE;
                1: addr = `RV32_CSR_CYCLEH;
                2: addr = `RV32_CSR_INSTRET;
                3: addr = `RV32_CSR_INSTRETH;
                7: addr = 12'h7C0; // Not implemented so it reads zero
                default: addr = `RV32_CSR_MSCRATCH;
            endcase
            csr_access(1'($urandom), csr_op_t'($urandom_range(1, 3)), 1'($urandom), addr,
                       $urandom, $urandom);
        end
    endtask

    task automatic check_held(input logic [4:0] rd, input logic [31:0] value);
        check("valid_out", 1, valid_out);
        check("rd_out", rd, rd_out);
        check("rd_write_out", 1, rd_write_out);
        check("rd_value_out", value, rd_value_out);
    endtask

    task automatic test_stall_flush();
        logic [31:0] addr;
        logic [31:0] victim;
        logic [31:0] held_value;
        logic [4:0]  held_rd;
        for (int i = 0; i < 16; i++) begin
            addr = rand_addr(2'd0);
            victim = rand_addr(2'd0);
            held_rd = 5'($urandom);
            held_value = model_load(addr, WIDTH_WORD, 1'b0);
            @(posedge clk);
            drive_mem(1'b1, 1'b0, WIDTH_WORD, addr, $urandom, 1'b0, held_rd);
            for (int s = 0; s < 4; s++) begin
                @(posedge clk); // First edge captures the load
                drive_mem(1'($urandom), 1'b1, WIDTH_WORD, victim, $urandom, 1'b0, 5'($urandom));
                stall <= 1'b1;
                @(negedge clk);
                check_held(held_rd, held_value);
            end
            @(posedge clk);
            set_idle();
            @(negedge clk);
            check_held(held_rd, held_value);
            load(WIDTH_WORD, victim, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            victim = rand_addr(2'd0);
            @(posedge clk);
            drive_mem(1'b0, 1'b1, mem_width_t'($urandom_range(0, 2)), victim, $urandom, 1'b0,
                      5'($urandom));
            rd_write_in <= 1'b1;
            flush <= 1'b1;
            @(posedge clk);
            set_idle();
            @(negedge clk);
            check("valid_out", 0, valid_out);
            check("rd_write_out", 0, rd_write_out);
            load(WIDTH_WORD, victim, 1'b0);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (fail_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, fail_count - errors_before);
        end
    endtask

    initial begin
        int unsigned seed_value;
        int          errors_before;
        int          cycles;
        $timeformat(-9, 0, " ns", 0);
        seed_value = $urandom(95825);
        pass_count = 0;
        fail_count = 0;
        scratch_model = 32'd0;
        set_idle();
        cycles = 0;
        while (reset !== 1'b0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset was still active after 100 clock cycles");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            errors_before = fail_count;
            test_word_access();
            report_test("word stores and loads", errors_before);
            errors_before = fail_count;
            test_sub_word();
            report_test("byte and half-word access", errors_before);
            errors_before = fail_count;
            test_branch();
            report_test("branch resolution", errors_before);
            errors_before = fail_count;
            test_csrs();
            report_test("CSR access", errors_before);
            errors_before = fail_count;
            test_stall_flush();
            report_test("stall and flush", errors_before);
            $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end
endmodule
